// File: Makefile
# Verilator build and run for the store queue testbench

VERILATOR ?= verilator
TOP       ?= stq_tb
FLIST     ?= stq.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: stq.f
+incdir+.
stq_mem_pkg.sv
stq_ctl_pkg.sv
stq_byte_mask.sv
stq_entry_array.sv
stq_age_pick.sv
stq_ptr_ctl.sv
stq_top.sv
stq_checker.sv
stq_tb.sv

// File: stq_age_pick.sv
// youngest older store pick
// keeps only matches between the head and the load's age tag, then
// takes the last one, searching the part below the load first when
// the window wraps
`timescale 1ns/1ns
`include "stq_settings.svh"

module stq_age_pick (
  input  logic [`STQ_DEPTH-1:0] match,
  input  stq_ctl_pkg::stq_tag_t head,
  input  stq_ctl_pkg::stq_tag_t load_tag,
  output logic                  hit,
  output stq_ctl_pkg::stq_tag_t pick
);

  import stq_ctl_pkg::*;

  logic [`STQ_DEPTH-1:0] below_load;
  logic [`STQ_DEPTH-1:0] from_head;
  logic [`STQ_DEPTH-1:0] window;
  logic [`STQ_DEPTH-1:0] cand_lo;
  logic [`STQ_DEPTH-1:0] cand_hi;
  logic [STQ_IDX_W-1:0]  idx_lo;
  logic [STQ_IDX_W-1:0]  idx_hi;
  logic [STQ_IDX_W-1:0]  idx_sel;
  logic                  has_lo;
  logic                  has_hi;

  function automatic logic [STQ_IDX_W-1:0] last_set(input logic [`STQ_DEPTH-1:0] v);
    int i;
    last_set = '0;
    for (i = 0; i < `STQ_DEPTH; i++) begin
      if (v[i]) last_set = STQ_IDX_W'(i);
    end
  endfunction

  for (genvar i = 0; i < `STQ_DEPTH; i++) begin : g_win
    assign below_load[i] = STQ_IDX_W'(i) < load_tag.idx;
    assign from_head[i]  = STQ_IDX_W'(i) >= head.idx;
  end

  // equal wrap bits mean head..load does not cross the top entry
  assign window = (head.wrap == load_tag.wrap) ? (below_load & from_head) :
                                                 (below_load | from_head);

  assign cand_lo = match & window & below_load;
  assign cand_hi = match & window & ~below_load;

  assign has_lo  = |cand_lo;
  assign has_hi  = |cand_hi;
  assign idx_lo  = last_set(cand_lo);
  assign idx_hi  = last_set(cand_hi);
  assign idx_sel = has_lo ? idx_lo : idx_hi;

  assign hit = has_lo | has_hi;

  // entries at or above the head are on the head's lap
  assign pick = '{
    wrap: (idx_sel >= head.idx) ? head.wrap : ~head.wrap,
    idx:  idx_sel
  };

endmodule

// File: stq_byte_mask.sv
// byte mask decode
// turns access size and the low address bits into the byte lanes an
// access touches inside its 4-byte word
`timescale 1ns/1ns

module stq_byte_mask (
  input  stq_mem_pkg::access_size_t size,
  input  logic [1:0]                low,
  output stq_mem_pkg::byte_mask_t   mask
);

  import stq_mem_pkg::*;

  always_comb begin
    mask = 4'b0000;
    case (size)
      SZ_BYTE: begin
        case (low)
          2'd0: mask = 4'b0001;
          2'd1: mask = 4'b0010;
          2'd2: mask = 4'b0100;
          default: mask = 4'b1000;
        endcase
      end
      SZ_HALF: begin
        // halves are aligned, so only low[1] picks the lane pair
        if (low[1]) begin
          mask = 4'b1100;
        end else begin
          mask = 4'b0011;
        end
      end
      SZ_WORD: begin
        mask = 4'b1111;
      end
      default: begin
        // unused size code, cover the whole word
        mask = 4'b1111;
      end
    endcase
  end

endmodule

// File: stq_checker.sv
// store queue checker
// compares alloc tags, check responses and drained stores with the
// values the testbench expects and counts mismatches
`timescale 1ns/1ns
`include "stq_settings.svh"

module stq_checker (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     alloc_valid,
  input  logic                     alloc_ready,
  input  stq_ctl_pkg::stq_tag_t    alloc_tag,
  input  logic                     exp_ready,
  input  stq_ctl_pkg::stq_tag_t    exp_tag,
  input  logic                     chk_valid,
  input  logic                     chk_resp_valid,
  input  stq_ctl_pkg::chk_resp_t   chk_resp,
  input  stq_ctl_pkg::chk_resp_t   exp_resp,
  input  logic                     drain_valid,
  input  stq_ctl_pkg::drain_word_t drain_out,
  input  logic                     drain_credit,
  input  logic                     push_valid,
  input  stq_ctl_pkg::drain_word_t push_word,
  output int                       errors,
  output int                       pending
);

  import stq_ctl_pkg::*;

  drain_word_t exp_q[$];
  chk_resp_t   resp_exp;
  logic        resp_due;
  int          in_flight;

  always @(posedge clk) begin
    if (rst) begin
      errors = 0;
      in_flight = 0;
      resp_due = 1'b0;
      exp_q.delete();
    end else begin
      if (alloc_valid && alloc_ready != exp_ready) begin
        errors++;
        $display("Error: alloc_ready exp %h got %h", exp_ready, alloc_ready);
      end else if (alloc_valid && alloc_ready && alloc_tag != exp_tag) begin
        errors++;
        $display("Error: alloc_tag exp %h got %h", exp_tag, alloc_tag);
      end
      if (chk_resp_valid != resp_due) begin
        errors++;
        $display("Error: chk_resp_valid exp %h got %h", resp_due, chk_resp_valid);
      end else if (resp_due && (chk_resp.hit != resp_exp.hit || chk_resp.full != resp_exp.full ||
                   (resp_exp.hit && chk_resp.tag != resp_exp.tag))) begin
        errors++;
        $display("Error: chk_resp exp %h got %h", resp_exp, chk_resp);
      end
      resp_due = chk_valid;
      resp_exp = exp_resp;
      if (drain_valid) begin
        if (in_flight >= `STQ_DRAIN_CREDITS) begin
          errors++;
          $display("a drain was sent with no credit left");
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("a store drained that was never committed");
        end else if (drain_out != exp_q[0]) begin
          errors++;
          $display("Error: drain_out exp %h got %h", exp_q[0], drain_out);
          void'(exp_q.pop_front());
        end else begin
          void'(exp_q.pop_front());
        end
      end
      in_flight = in_flight + int'(drain_valid) - int'(drain_credit);
      if (push_valid) exp_q.push_back(push_word);
    end
    pending = exp_q.size();
  end

endmodule

// File: stq_ctl_pkg.sv
// store queue control types
// age tags, store write and load check requests, check response and
// the word sent to the data cache on drain
`include "stq_settings.svh"

package stq_ctl_pkg;

  localparam int STQ_IDX_W = $clog2(`STQ_DEPTH);
  localparam int STQ_TAG_W = STQ_IDX_W + 1;

  // wrap bit flips each time the index rolls over
  typedef struct packed {
    logic                 wrap;
    logic [STQ_IDX_W-1:0] idx;
  } stq_tag_t;

  typedef struct packed {
    stq_tag_t               tag;
    stq_mem_pkg::mem_req_t  req;
    logic [`STQ_DATA_W-1:0] data;
  } store_wr_t;

  // tag is the tail tag seen when the load was dispatched
  typedef struct packed {
    stq_mem_pkg::mem_req_t req;
    stq_tag_t              tag;
  } chk_req_t;

  typedef struct packed {
    logic     hit;
    logic     full;
    stq_tag_t tag;
  } chk_resp_t;

  typedef struct packed {
    logic [stq_mem_pkg::STQ_WORD_W-1:0] word;
    stq_mem_pkg::byte_mask_t            mask;
    logic [`STQ_DATA_W-1:0]             data;
  } drain_word_t;

endpackage

// File: stq_entry_array.sv
// store queue entry array
// holds word address, byte mask and data of every store and compares
// a load against all entries in parallel
// also reads out the entry at the drain index
`timescale 1ns/1ns
`include "stq_settings.svh"

module stq_entry_array (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              store_wr_valid,
  input  stq_ctl_pkg::store_wr_t            store_wr,
  input  stq_mem_pkg::byte_mask_t           store_mask,
  input  stq_ctl_pkg::chk_req_t             chk_req,
  input  stq_mem_pkg::byte_mask_t           chk_mask,
  input  logic [`STQ_DEPTH-1:0]             entry_valid,
  input  logic [stq_ctl_pkg::STQ_IDX_W-1:0] drain_idx,
  output logic [`STQ_DEPTH-1:0]             match,
  output logic [`STQ_DEPTH-1:0]             full_cov,
  output stq_ctl_pkg::drain_word_t          drain_out
);

  import stq_mem_pkg::*;
  import stq_ctl_pkg::*;

  stq_entry_t ent_q [`STQ_DEPTH];
  stq_entry_t drain_ent;

  for (genvar i = 0; i < `STQ_DEPTH; i++) begin : g_ent
    logic       wr_sel;
    byte_mask_t overlap;

    assign wr_sel = store_wr_valid && (store_wr.tag.idx == STQ_IDX_W'(i));

    // address-known bit, dropped once the entry is no longer valid
    always_ff @(posedge clk) begin
      if (rst) begin
        ent_q[i].known <= 1'b0;
      end else if (wr_sel) begin
        ent_q[i].known <= 1'b1;
      end else if (!entry_valid[i]) begin
        ent_q[i].known <= 1'b0;
      end
    end

    always_ff @(posedge clk) begin
      if (wr_sel) begin
        ent_q[i].word <= store_wr.req.addr.word;
        ent_q[i].mask <= store_mask;
        ent_q[i].data <= store_wr.data;
      end
    end

    assign overlap = ent_q[i].mask & chk_mask;

    // same word and at least one shared byte lane
    assign match[i] = entry_valid[i] && ent_q[i].known &&
                      (ent_q[i].word == chk_req.req.addr.word) && (|overlap);

    // store supplies every byte the load wants
    assign full_cov[i] = match[i] && (overlap == chk_mask);
  end

  assign drain_ent = ent_q[drain_idx];

  assign drain_out = '{
    word: drain_ent.word,
    mask: drain_ent.mask,
    data: drain_ent.data
  };

endmodule

// File: stq_mem_pkg.sv
// store queue memory-access types
// address split into word and low bits, access size, byte mask and
// the contents of one queue entry
`include "stq_settings.svh"

package stq_mem_pkg;

  localparam int STQ_WORD_W = `STQ_ADDR_W - 2;

  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } access_size_t;

  // one bit per byte lane of the 4-byte word
  typedef logic [3:0] byte_mask_t;

  typedef struct packed {
    logic [STQ_WORD_W-1:0] word;
    logic [1:0]            low;
  } mem_addr_t;

  typedef struct packed {
    mem_addr_t    addr;
    access_size_t size;
  } mem_req_t;

  // known is the only field that gets a reset
  typedef struct packed {
    logic                  known;
    logic [STQ_WORD_W-1:0] word;
    byte_mask_t            mask;
    logic [`STQ_DATA_W-1:0] data;
  } stq_entry_t;

endpackage

// File: stq_ptr_ctl.sv
// store queue pointer control
// head, commit and tail tags, per-entry valid bits, flush on
// exception and the credit-gated drain to the data cache
`timescale 1ns/1ns
`include "stq_settings.svh"

module stq_ptr_ctl (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              alloc_valid,
  output logic                              alloc_ready,
  output stq_ctl_pkg::stq_tag_t             alloc_tag,
  input  logic                              commit_valid,
  input  logic                              excpt,
  input  logic                              drain_credit,
  output logic [`STQ_DEPTH-1:0]             entry_valid,
  output stq_ctl_pkg::stq_tag_t             head,
  output logic                              drain_valid,
  output logic [stq_ctl_pkg::STQ_IDX_W-1:0] drain_idx
);

  import stq_ctl_pkg::*;

  localparam int CRED_W = $clog2(`STQ_DRAIN_CREDITS + 1);
  localparam logic [CRED_W-1:0] CRED_MAX = `STQ_DRAIN_CREDITS;

  stq_tag_t              head_q, cmt_q, tail_q, cmt_d;
  logic [`STQ_DEPTH-1:0] valid_q, valid_d, keep;
  logic [CRED_W-1:0]     credits_q;
  logic [STQ_TAG_W-1:0]  cmt_cnt;
  logic                  full, alloc_fire, commit_fire, drain_fire;

  function automatic stq_tag_t tag_inc(input stq_tag_t t);
    tag_inc = stq_tag_t'(t + 1'b1);
  endfunction

  assign full        = (head_q.idx == tail_q.idx) && (head_q.wrap != tail_q.wrap);
  assign alloc_fire  = alloc_valid && !full && !excpt;
  assign commit_fire = commit_valid && (cmt_q != tail_q);
  assign drain_fire  = (credits_q != '0) && (cmt_q != head_q);

  assign cmt_d   = commit_fire ? tag_inc(cmt_q) : cmt_q;
  assign cmt_cnt = cmt_d - head_q;

  // committed entries survive a flush
  for (genvar i = 0; i < `STQ_DEPTH; i++) begin : g_keep
    logic [STQ_IDX_W-1:0] pos;
    assign pos     = STQ_IDX_W'(i) - head_q.idx;
    assign keep[i] = {1'b0, pos} < cmt_cnt;
  end

  always_comb begin
    valid_d = valid_q;
    if (drain_fire) valid_d[head_q.idx] = 1'b0;
    if (excpt) begin
      valid_d = valid_d & keep;
    end else if (alloc_fire) begin
      valid_d[tail_q.idx] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q    <= '0;
      cmt_q     <= '0;
      tail_q    <= '0;
      valid_q   <= '0;
      credits_q <= CRED_MAX;
    end else begin
      valid_q <= valid_d;
      cmt_q   <= cmt_d;
      if (drain_fire) head_q <= tag_inc(head_q);
      if (excpt) begin
        tail_q <= cmt_d;
      end else if (alloc_fire) begin
        tail_q <= tag_inc(tail_q);
      end
      if (drain_fire && !drain_credit) begin
        credits_q <= credits_q - 1'b1;
      end else if (!drain_fire && drain_credit && credits_q != CRED_MAX) begin
        credits_q <= credits_q + 1'b1;
      end
    end
  end

  assign alloc_ready = !full;
  assign alloc_tag   = tail_q;
  assign entry_valid = valid_q;
  assign head        = head_q;
  assign drain_valid = drain_fire;
  assign drain_idx   = head_q.idx;

endmodule

// File: stq_settings.svh
// store queue build settings
// queue depth, address and data widths, and drain credits shared by
// the packages and the RTL
`ifndef STQ_SETTINGS_SVH
`define STQ_SETTINGS_SVH

// number of queue entries, must stay a power of two
`define STQ_DEPTH 16

// byte address width
`define STQ_ADDR_W 32

// store data width, one 4-byte word
`define STQ_DATA_W 32

// credits the data cache grants after reset
`define STQ_DRAIN_CREDITS 2

`endif

// File: stq_tb.sv
// store queue testbench
// applies a table of alloc, write, check, commit and exception steps,
// keeps a model of the stores and returns drain credits at random
`timescale 1ns/1ns
`include "stq_settings.svh"

module stq_tb;

  import stq_mem_pkg::*;
  import stq_ctl_pkg::*;

  typedef enum int {OP_IDLE, OP_ALLOC, OP_WRITE, OP_CHECK, OP_COMMIT, OP_EXCPT, OP_WAIT} op_t;

  // alloc rows hold the expected tag in tag and the expected ready in ea
  // check rows hold the load tag, hit in ea, full in eb and the picked store in etag
  typedef struct {
    op_t         op;
    logic [4:0]  tag;
    logic [31:0] addr;
    logic [1:0]  size;
    logic [31:0] data;
    logic        ea;
    logic        eb;
    logic [4:0]  etag;
  } row_t;

  logic clk, rst, alloc_valid, alloc_ready, store_wr_valid, chk_valid, chk_resp_valid;
  logic commit_valid, excpt, drain_valid, drain_credit, exp_ready, push_valid;
  stq_tag_t    alloc_tag, exp_tag;
  store_wr_t   store_wr;
  chk_req_t    chk_req;
  chk_resp_t   chk_resp, exp_resp;
  drain_word_t drain_out, push_word;
  int          errors, pending, timeouts, outstanding, nxt, waited, mdl_cmt;
  int          seed = 73108;
  logic [31:0] rnd;
  row_t        rows[$];
  logic [29:0] mdl_word [`STQ_DEPTH];
  logic [3:0]  mdl_mask [`STQ_DEPTH];
  logic [31:0] mdl_data [`STQ_DEPTH];

  stq_top dut0 (.*);

  stq_checker chk0 (.*);

  function automatic logic [3:0] lanes(input logic [1:0] size, input logic [1:0] low);
    case (size)
      2'd0: lanes = 4'b0001 << low;
      2'd1: lanes = 4'b0011 << {low[1], 1'b0};
      default: lanes = 4'b1111;
    endcase
  endfunction

  task automatic add(input op_t op, input logic [4:0] tag, input logic [31:0] addr,
                     input logic [1:0] size, input logic [31:0] data, input logic ea,
                     input logic eb, input logic [4:0] etag);
    rows.push_back('{op, tag, addr, size, data, ea, eb, etag});
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // one credit comes back per drain after a random delay
  always @(posedge clk) begin
    if (rst) begin
      outstanding = 0;
      drain_credit <= 1'b0;
    end else begin
      nxt = outstanding + int'(drain_valid) - int'(drain_credit);
      outstanding = nxt;
      rnd = $random(seed);
      drain_credit <= (nxt > 0) && rnd[0];
    end
  end

  initial begin
    rst <= 1'b1;
    {alloc_valid, store_wr_valid, chk_valid, commit_valid, excpt} <= '0;
    {exp_ready, push_valid} <= '0;
    drain_credit <= 1'b0;
    store_wr <= '0;
    chk_req <= '0;
    exp_tag <= '0;
    exp_resp <= '0;
    push_word <= '0;
    timeouts = 0;
    mdl_cmt = 0;
    // basic hits, partial cover, disjoint and younger stores
    add(OP_ALLOC, 5'h00, 0, 0, 0, 1, 0, 0);
    add(OP_ALLOC, 5'h01, 0, 0, 0, 1, 0, 0);
    add(OP_ALLOC, 5'h02, 0, 0, 0, 1, 0, 0);
    add(OP_ALLOC, 5'h03, 0, 0, 0, 1, 0, 0);
    add(OP_WRITE, 5'h00, 32'h100, 2, 32'h11223344, 0, 0, 0);
    add(OP_WRITE, 5'h01, 32'h105, 0, 32'h0000aa00, 0, 0, 0);
    add(OP_WRITE, 5'h02, 32'h200, 2, 32'h55667788, 0, 0, 0);
    add(OP_WRITE, 5'h03, 32'h102, 1, 32'hbeef0000, 0, 0, 0);
    add(OP_CHECK, 5'h01, 32'h100, 2, 0, 1, 1, 5'h00);
    add(OP_CHECK, 5'h03, 32'h104, 2, 0, 1, 0, 5'h01);
    add(OP_CHECK, 5'h03, 32'h106, 0, 0, 0, 0, 0);
    add(OP_CHECK, 5'h00, 32'h100, 2, 0, 0, 0, 0);
    add(OP_CHECK, 5'h04, 32'h100, 2, 0, 1, 0, 5'h03);
    add(OP_CHECK, 5'h03, 32'h100, 0, 0, 1, 1, 5'h00);
    for (int i = 0; i < 4; i++) add(OP_COMMIT, 0, 0, 0, 0, 0, 0, 0);
    add(OP_WAIT, 0, 0, 0, 0, 0, 0, 0);
    // fill the queue so the tags wrap, then check across the wrap
    for (int i = 0; i < 16; i++) add(OP_ALLOC, 5'(4 + i), 0, 0, 0, 1, 0, 0);
    add(OP_ALLOC, 0, 0, 0, 0, 0, 0, 0);
    for (int i = 0; i < 16; i++) begin
      add(OP_WRITE, 5'(4 + i), (i == 10 || i == 13) ? 32'h400 : 32'h1000 + 4 * i, 2,
          32'ha0000000 + i, 0, 0, 0);
    end
    add(OP_CHECK, 5'h12, 32'h400, 2, 0, 1, 1, 5'h11);
    add(OP_CHECK, 5'h10, 32'h400, 2, 0, 1, 1, 5'h0e);
    for (int i = 0; i < 8; i++) add(OP_COMMIT, 0, 0, 0, 0, 0, 0, 0);
    add(OP_ALLOC, 5'h14, 0, 0, 0, 1, 0, 0);
    add(OP_EXCPT, 0, 0, 0, 0, 0, 0, 0);
    add(OP_CHECK, 5'h15, 32'h400, 2, 0, 0, 0, 0);
    add(OP_WAIT, 0, 0, 0, 0, 0, 0, 0);
    add(OP_ALLOC, 5'h0c, 0, 0, 0, 1, 0, 0);
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    foreach (rows[r]) begin
      @(posedge clk);
      {alloc_valid, store_wr_valid, chk_valid, commit_valid, excpt, push_valid} <= '0;
      case (rows[r].op)
        OP_ALLOC: begin
          alloc_valid <= 1'b1;
          exp_ready <= rows[r].ea;
          exp_tag <= rows[r].tag;
        end
        OP_WRITE: begin
          store_wr_valid <= 1'b1;
          store_wr <= '{tag: rows[r].tag, data: rows[r].data,
                        req: '{addr: rows[r].addr, size: access_size_t'(rows[r].size)}};
          mdl_word[rows[r].tag[3:0]] = rows[r].addr[31:2];
          mdl_mask[rows[r].tag[3:0]] = lanes(rows[r].size, rows[r].addr[1:0]);
          mdl_data[rows[r].tag[3:0]] = rows[r].data;
        end
        OP_CHECK: begin
          chk_valid <= 1'b1;
          chk_req <= '{req: '{addr: rows[r].addr, size: access_size_t'(rows[r].size)},
                       tag: rows[r].tag};
          exp_resp <= '{hit: rows[r].ea, full: rows[r].eb, tag: rows[r].etag};
        end
        OP_COMMIT: begin
          commit_valid <= 1'b1;
          push_valid <= 1'b1;
          push_word <= '{word: mdl_word[mdl_cmt % 16], mask: mdl_mask[mdl_cmt % 16],
                         data: mdl_data[mdl_cmt % 16]};
          mdl_cmt++;
        end
        OP_EXCPT: excpt <= 1'b1;
        OP_WAIT: begin
          waited = 0;
          @(negedge clk);
          while (pending != 0 && waited < 200) begin
            @(negedge clk);
            waited++;
          end
          if (pending != 0) begin
            timeouts++;
            $display("timeout waiting for committed stores to drain");
          end
        end
        default: ;
      endcase
    end
    @(posedge clk);
    {alloc_valid, store_wr_valid, chk_valid, commit_valid, excpt, push_valid} <= '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    $display("checker errors %0d, timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: stq_top.sv
// store queue top level
// ties pointer control, entry array, age pick and the two byte mask
// decoders together and registers the load check response
`timescale 1ns/1ns
`include "stq_settings.svh"

module stq_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     alloc_valid,
  output logic                     alloc_ready,
  output stq_ctl_pkg::stq_tag_t    alloc_tag,
  input  logic                     store_wr_valid,
  input  stq_ctl_pkg::store_wr_t   store_wr,
  input  logic                     chk_valid,
  input  stq_ctl_pkg::chk_req_t    chk_req,
  output logic                     chk_resp_valid,
  output stq_ctl_pkg::chk_resp_t   chk_resp,
  input  logic                     commit_valid,
  input  logic                     excpt,
  output logic                     drain_valid,
  output stq_ctl_pkg::drain_word_t drain_out,
  input  logic                     drain_credit
);

  import stq_mem_pkg::*;
  import stq_ctl_pkg::*;

  byte_mask_t            st_mask, ld_mask;
  logic [`STQ_DEPTH-1:0] entry_valid, match, full_cov;
  logic [STQ_IDX_W-1:0]  drain_idx;
  stq_tag_t              head, pick;
  logic                  hit;
  chk_resp_t             resp_d;

  stq_byte_mask u_st_mask (.size(store_wr.req.size), .low(store_wr.req.addr.low), .mask(st_mask));
  stq_byte_mask u_ld_mask (.size(chk_req.req.size), .low(chk_req.req.addr.low), .mask(ld_mask));

  stq_ptr_ctl u_ptr (
    .clk(clk), .rst(rst), .alloc_valid(alloc_valid), .alloc_ready(alloc_ready),
    .alloc_tag(alloc_tag), .commit_valid(commit_valid), .excpt(excpt),
    .drain_credit(drain_credit), .entry_valid(entry_valid), .head(head),
    .drain_valid(drain_valid), .drain_idx(drain_idx)
  );

  stq_entry_array u_array (
    .clk(clk), .rst(rst), .store_wr_valid(store_wr_valid), .store_wr(store_wr),
    .store_mask(st_mask), .chk_req(chk_req), .chk_mask(ld_mask),
    .entry_valid(entry_valid), .drain_idx(drain_idx), .match(match),
    .full_cov(full_cov), .drain_out(drain_out)
  );

  stq_age_pick u_pick (.match(match), .head(head), .load_tag(chk_req.tag), .hit(hit), .pick(pick));

  // full only counts for the store that was picked
  assign resp_d = '{hit: hit, full: hit && full_cov[pick.idx], tag: pick};

  always_ff @(posedge clk) begin
    if (rst) begin
      chk_resp_valid <= 1'b0;
    end else begin
      chk_resp_valid <= chk_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (chk_valid) chk_resp <= resp_d;
  end

endmodule
